//--- Bender.yml
package:
  name: icache

sources:
  - include_dirs:
      - source
    files:
      - source/icache_pkg.sv
      - source/icache_cfg_regs.sv
      - source/icache_way_store.sv
      - source/icache_refill.sv
      - source/icache_ctrl.sv
      - source/icache_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - bench/icache_assert.sv
      - bench/icache_tb.sv

//--- bench/icache_assert.sv
/*
 * Protocol checks on the fetch port and both Wishbone buses
 */
`timescale 1ns/1ps

module icache_assert
   import icache_pkg::*;
(
   input logic    clk,
   input logic    rst_n,
   input logic    fetch_grant_i,
   input logic    fetch_rsp_valid_i,
   input wb_m2s_t mem_req_i,
   input wb_m2s_t cfg_req_i
);

   // ----------------------------------------------------------
   // Wishbone framing
   // ----------------------------------------------------------
   mem_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
      mem_req_i.stb |-> mem_req_i.cyc)
      else $error("memory stb outside cyc");

   cfg_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
      cfg_req_i.stb |-> cfg_req_i.cyc)
      else $error("configuration stb outside cyc");

   // Responses last one cycle, no fetch taken during a memory cycle
   rsp_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      fetch_rsp_valid_i |=> !fetch_rsp_valid_i)
      else $error("fetch response longer than one cycle");

   no_grant_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
      mem_req_i.cyc |-> !fetch_grant_i)
      else $error("fetch grant during memory cycle");

endmodule

//--- bench/icache_stim.txt
# Columns: op (F fetch, W cfg write, R cfg read), address or offset (hex),
# fetch ID or write data (hex), class HIT/MISS/BYPASS, or read value (hex)
F 00000100 1 BYPASS
F 00000104 2 BYPASS
R 8 0 00000000
R C 0 00000000
W 0 1 -
R 0 0 00000001
F 00000100 3 MISS
F 00000104 4 HIT
F 0000010C 5 HIT
F 00000108 6 HIT
# Set 2 replacement, oldest fill goes first
F 00001020 7 MISS
F 00002024 8 MISS
F 00001028 9 HIT
F 00003020 A MISS
F 0000202C B HIT
F 00001020 C MISS
F 00003024 D HIT
F 00002020 E MISS
W 4 1 -
F 00000100 F MISS
F 00000108 0 HIT
F 0000010C 2 HIT
R 8 0 00000008
R C 0 00000007
W 8 0 -
W C 0 -
R 8 0 00000000
R C 0 00000000
W 0 0 -
F 00000104 1 BYPASS
R 8 0 00000000

//--- bench/icache_tb.sv
/*
 * Instruction cache testbench, runs the stimulus file against a Wishbone
 * memory model with random wait states
 */
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_tb
   import icache_pkg::*;
;

   localparam logic [31:0] DATA_KEY    = 32'hA5A5A5A5;   // Memory word = address ^ key
   localparam int          GRANT_LIMIT = 50;
   localparam int          RSP_LIMIT   = 200;
   localparam int          ACK_LIMIT   = 200;

   logic       clk;
   logic       rst_n;
   logic       fetch_req_valid;
   fetch_req_t fetch_req;
   logic       fetch_grant;
   logic       fetch_rsp_valid;
   fetch_rsp_t fetch_rsp;
   wb_m2s_t    mem_req;
   wb_s2m_t    mem_rsp   = '0;
   wb_m2s_t    cfg_req;
   wb_s2m_t    cfg_rsp;

   // Memory model state
   logic [31:0] rng_state = 32'd69;
   int          wait_cnt  = 0;
   logic [31:0] beat_addrs[$];   // Addresses of beats since the last fetch started

   int errors      = 0;
   int tests       = 0;
   int failed      = 0;
   int hits_seen   = 0;
   int misses_seen = 0;

   icache_top UUT (
      .clk               (clk),
      .rst_n             (rst_n),
      .fetch_req_valid_i (fetch_req_valid),
      .fetch_req_i       (fetch_req),
      .fetch_grant_o     (fetch_grant),
      .fetch_rsp_valid_o (fetch_rsp_valid),
      .fetch_rsp_o       (fetch_rsp),
      .mem_wb_o          (mem_req),
      .mem_wb_i          (mem_rsp),
      .cfg_wb_i          (cfg_req),
      .cfg_wb_o          (cfg_rsp)
   );

   bind icache_top icache_assert u_assert (
      .clk               (clk),
      .rst_n             (rst_n),
      .fetch_grant_i     (fetch_grant_o),
      .fetch_rsp_valid_i (fetch_rsp_valid_o),
      .mem_req_i         (mem_wb_o),
      .cfg_req_i         (cfg_wb_i)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // ----------------------------------------------------------
   // Wishbone memory, 0 to 3 wait states per beat
   // ----------------------------------------------------------
   always @(negedge clk)
   begin
      if (mem_req.cyc && mem_req.stb && wait_cnt == 0)
      begin
         mem_rsp.ack = 1'b1;
         mem_rsp.dat = {mem_req.adr[31:2], 2'b00} ^ DATA_KEY;
         beat_addrs.push_back(mem_req.adr);
         compare_value("mem_wb_o.we", 32'(mem_req.we), 32'h0);    // Reads only
         compare_value("mem_wb_o.sel", 32'(mem_req.sel), 32'hF);  // Full word
         rng_state   = xorshift32(rng_state);
         wait_cnt    = int'(rng_state[1:0]);
      end
      else
      begin
         mem_rsp.ack = 1'b0;
         if (mem_req.cyc && mem_req.stb)
            wait_cnt--;
      end
   end

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      assert (got === exp)
      else
      begin
         $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic require(input bit cond, input string what);
      assert (cond)
      else
      begin
         $display("%0t: %s", $time, what);
         errors++;
      end
   endtask

   // One fetch, checked against its expected class
   task automatic run_fetch(input logic [31:0] addr, input logic [3:0] id, input string cls);
      int          cycles;
      logic [31:0] line_base;
      line_base = {addr[31:4], 4'h0};
      beat_addrs.delete();
      cycles = 0;
      while (!fetch_grant && cycles < GRANT_LIMIT)
      begin
         @(negedge clk);
         cycles++;
      end
      require(fetch_grant, $sformatf("fetch of %h was never granted", addr));
      fetch_req_valid = 1'b1;
      fetch_req.addr  = addr;
      fetch_req.id    = id;
      cycles = 0;
      do
      begin
         @(negedge clk);
         cycles++;
         fetch_req_valid = 1'b0;   // Taken on the edge just passed
      end
      while (!fetch_rsp_valid && cycles < RSP_LIMIT);
      require(fetch_rsp_valid, $sformatf("no response for fetch of %h", addr));
      if (!fetch_rsp_valid)
         return;
      compare_value("fetch_rsp_o.data", fetch_rsp.data, {addr[31:2], 2'b00} ^ DATA_KEY);
      compare_value("fetch_rsp_o.id", 32'(fetch_rsp.id), 32'(id));
      if (cls == "HIT")
      begin
         compare_value("hit latency", cycles, 2);
         compare_value("memory beats", beat_addrs.size(), 0);
         hits_seen++;
      end
      else if (cls == "MISS")
      begin
         compare_value("memory beats", beat_addrs.size(), 4);
         for (int i = 0; i < beat_addrs.size() && i < 4; i++)
            compare_value("mem_wb_o.adr", beat_addrs[i], line_base + 32'(4 * i));
         misses_seen++;
      end
      else if (cls == "BYPASS")
      begin
         compare_value("memory beats", beat_addrs.size(), 1);
         if (beat_addrs.size() > 0)
            compare_value("mem_wb_o.adr", beat_addrs[0], {addr[31:2], 2'b00});
      end
      else
         require(1'b0, $sformatf("unknown fetch class %s in stimulus", cls));
   endtask

   // Single configuration access, waits for the ack
   task automatic cfg_access(input logic we, input logic [3:0] offset,
                             input logic [31:0] wdata, output logic [31:0] rdata);
      int cycles;
      cfg_req     = '0;
      cfg_req.cyc = 1'b1;
      cfg_req.stb = 1'b1;
      cfg_req.we  = we;
      cfg_req.adr = 32'(offset);
      cfg_req.dat = wdata;
      cfg_req.sel = '1;
      cycles = 0;
      do
      begin
         @(negedge clk);
         cycles++;
      end
      while (!cfg_rsp.ack && cycles < ACK_LIMIT);
      require(cfg_rsp.ack, $sformatf("configuration access at offset %h never acked", offset));
      rdata   = cfg_rsp.dat;
      cfg_req = '0;
   endtask

   // ----------------------------------------------------------
   // Main sequence
   // ----------------------------------------------------------
   initial
   begin
      int          fd;
      int          code;
      int          err_before;
      string       line;
      string       op;
      string       cls;
      logic [31:0] addr;
      logic [31:0] val;
      logic [31:0] expv;
      logic [31:0] rdata;
      rst_n           = 1'b0;
      fetch_req_valid = 1'b0;
      fetch_req       = '0;
      cfg_req         = '0;
      repeat (8) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);

      fd = $fopen("bench/icache_stim.txt", "r");
      require(fd != 0, "cannot open the stimulus file");
      while (fd != 0 && !$feof(fd))
      begin
         line = "";
         code = $fgets(line, fd);
         if (line.len() < 2 || line[0] == "#")
            continue;
         code = $sscanf(line, "%s %h %h %s", op, addr, val, cls);
         err_before = errors;
         tests++;
         if (code < 4)
            require(1'b0, $sformatf("malformed stimulus line %s", line));
         else if (op == "F")
            run_fetch(addr, val[3:0], cls);
         else if (op == "W")
         begin
            cfg_access(1'b1, addr[3:0], val, rdata);
            if (addr[3:0] == `ICACHE_REG_HITS)
               hits_seen = 0;
            if (addr[3:0] == `ICACHE_REG_MISSES)
               misses_seen = 0;
         end
         else if (op == "R")
         begin
            code = $sscanf(line, "%s %h %h %h", op, addr, val, expv);
            cfg_access(1'b0, addr[3:0], 32'h0, rdata);
            compare_value("cfg_wb_o.dat", rdata, expv);
            if (addr[3:0] == `ICACHE_REG_HITS)
               compare_value("hit counter", rdata, 32'(hits_seen));
            if (addr[3:0] == `ICACHE_REG_MISSES)
               compare_value("miss counter", rdata, 32'(misses_seen));
         end
         else
            require(1'b0, $sformatf("unknown operation %s in stimulus", op));
         if (errors != err_before)
            failed++;
         $display("test %0d: %s %h %s", tests, op, addr, (errors == err_before) ? "ok" : "failed");
      end
      if (fd != 0)
         $fclose(fd);

      $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
      if (errors == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

//--- flist.f
+incdir+source
source/icache_pkg.sv
source/icache_cfg_regs.sv
source/icache_way_store.sv
source/icache_refill.sv
source/icache_ctrl.sv
source/icache_top.sv
bench/icache_assert.sv
bench/icache_tb.sv

//--- source/icache_cfg_regs.sv
/*
 * Configuration registers: enable, flush command and hit/miss counters
 */
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_cfg_regs
   import icache_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  wb_m2s_t    cfg_wb_i,
   output wb_s2m_t    cfg_wb_o,
   input  cache_evt_t evt_i,
   input  logic       flush_done_i,
   output logic       enable_o,
   output logic       flush_pending_o
);

   cfg_reg_e                  reg_sel;
   logic                      req;
   logic                      wr;
   logic                      flush_wr;
   logic                      ack_q;
   logic                      enable_q;
   logic                      pending_q;
   logic [`ICACHE_WORD_W-1:0] hits_q;
   logic [`ICACHE_WORD_W-1:0] misses_q;
   logic [`ICACHE_WORD_W-1:0] rdata_q;

   always_comb
   begin
      case (cfg_wb_i.adr[`ICACHE_CFG_ADDR_W-1:0])
         `ICACHE_REG_FLUSH:  reg_sel = REG_FLUSH;
         `ICACHE_REG_HITS:   reg_sel = REG_HITS;
         `ICACHE_REG_MISSES: reg_sel = REG_MISSES;
         default:            reg_sel = REG_CTRL;
      endcase
   end

   assign req      = cfg_wb_i.cyc & cfg_wb_i.stb & ~ack_q;   // Open, not yet acked
   assign wr       = req & cfg_wb_i.we;
   assign flush_wr = wr & (reg_sel == REG_FLUSH) & cfg_wb_i.dat[0];

   // ----------------------------------------------------------
   // Handshake, enable and counters
   // ----------------------------------------------------------
   always_ff @(posedge clk, negedge rst_n)
   begin
      if (!rst_n)
      begin
         ack_q     <= 1'b0;
         enable_q  <= 1'b0;
         pending_q <= 1'b0;
         hits_q    <= '0;
         misses_q  <= '0;
      end
      else
      begin
         ack_q <= 1'b0;
         if (flush_done_i)
         begin
            pending_q <= 1'b0;
            ack_q     <= 1'b1;   // Late ack of the flush write
         end
         else if (flush_wr)
            pending_q <= 1'b1;
         else if (req)
            ack_q <= 1'b1;

         if (wr && reg_sel == REG_CTRL)
            enable_q <= cfg_wb_i.dat[0];

         if (wr && reg_sel == REG_HITS)
            hits_q <= '0;
         else if (evt_i.hit)
            hits_q <= hits_q + 1'b1;

         if (wr && reg_sel == REG_MISSES)
            misses_q <= '0;
         else if (evt_i.miss)
            misses_q <= misses_q + 1'b1;
      end
   end

   // Read data, sampled with the request
   always_ff @(posedge clk)
   begin
      if (req)
      begin
         case (reg_sel)
            REG_CTRL:  rdata_q <= {{(`ICACHE_WORD_W-1){1'b0}}, enable_q};
            REG_FLUSH: rdata_q <= {{(`ICACHE_WORD_W-1){1'b0}}, pending_q};
            REG_HITS:  rdata_q <= hits_q;
            default:   rdata_q <= misses_q;
         endcase
      end
   end

   assign cfg_wb_o.ack     = ack_q;
   assign cfg_wb_o.dat     = rdata_q;
   assign enable_o         = enable_q;
   assign flush_pending_o  = pending_q;

endmodule

//--- source/icache_ctrl.sv
/*
 * Cache controller FSM for lookup, refill, bypass and flush
 */
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_ctrl
   import icache_pkg::*;
(
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        fetch_req_valid_i,
   input  fetch_req_t                  fetch_req_i,
   output logic                        fetch_grant_o,
   output logic                        fetch_rsp_valid_o,
   output fetch_rsp_t                  fetch_rsp_o,
   input  logic                        enable_i,
   input  logic                        flush_pending_i,
   output logic                        flush_done_o,
   output cache_evt_t                  evt_o,
   output logic [`ICACHE_INDEX_W-1:0]  ws_index_o,
   output logic                        ws_lookup_o,
   output logic [`ICACHE_TAG_W-1:0]    ws_tag_o,
   output logic [`ICACHE_OFFSET_W-1:0] ws_word_o,
   output logic                        ws_fill_o,
   output cache_line_t                 ws_fill_line_o,
   output logic                        ws_inval_all_o,
   input  logic                        ws_hit_i,
   input  logic [`ICACHE_WORD_W-1:0]   ws_hit_word_i,
   output logic                        rf_start_o,
   output logic                        rf_single_o,
   output logic [`ICACHE_ADDR_W-1:0]   rf_addr_o,
   input  logic                        rf_done_i,
   input  cache_line_t                 rf_line_i,
   input  logic [`ICACHE_WORD_W-1:0]   rf_word_i
);

   localparam int IDX_LSB = 2 + `ICACHE_OFFSET_W;
   localparam int TAG_LSB = IDX_LSB + `ICACHE_INDEX_W;

   cache_state_e                state_q;
   cache_state_e                state_d;
   fetch_req_t                  req_q;
   logic [`ICACHE_WORD_W-1:0]   rsp_word_q;
   logic                        accept;
   logic                        lookup;
   logic [`ICACHE_TAG_W-1:0]    req_tag;
   logic [`ICACHE_INDEX_W-1:0]  req_index;
   logic [`ICACHE_OFFSET_W-1:0] req_word;

   assign req_tag   = req_q.addr[`ICACHE_ADDR_W-1:TAG_LSB];
   assign req_index = req_q.addr[TAG_LSB-1:IDX_LSB];
   assign req_word  = req_q.addr[IDX_LSB-1:2];

   assign fetch_grant_o = (state_q == IDLE) & ~flush_pending_i;   // Flush wins over fetches
   assign accept        = fetch_req_valid_i & fetch_grant_o;
   assign lookup        = state_q == LOOKUP;

   // ----------------------------------------------------------
   // State machine
   // ----------------------------------------------------------
   always_comb
   begin
      state_d = state_q;
      case (state_q)
         IDLE:
         begin
            if (flush_pending_i)
               state_d = FLUSH;
            else if (accept)
               state_d = enable_i ? LOOKUP : BYPASS;
         end
         LOOKUP:         state_d = ws_hit_i ? RESPOND : REFILL;
         REFILL, BYPASS: state_d = rf_done_i ? RESPOND : state_q;
         default:        state_d = IDLE;   // RESPOND and FLUSH last one cycle
      endcase
   end

   always_ff @(posedge clk, negedge rst_n)
   begin
      if (!rst_n)
         state_q <= IDLE;
      else
         state_q <= state_d;
   end

   always_ff @(posedge clk)
   begin
      if (accept)
         req_q <= fetch_req_i;
      if (lookup)
         rsp_word_q <= ws_hit_word_i;
      else if (rf_done_i)
         rsp_word_q <= (state_q == BYPASS) ? rf_word_i : rf_line_i[req_word];
   end

   // ----------------------------------------------------------
   // Store and refill control
   // ----------------------------------------------------------
   // Store read starts on the grant edge, so index comes straight from the port
   assign ws_index_o     = (state_q == IDLE) ? fetch_req_i.addr[TAG_LSB-1:IDX_LSB] : req_index;
   assign ws_lookup_o    = accept & enable_i;
   assign ws_tag_o       = req_tag;
   assign ws_word_o      = req_word;
   assign ws_fill_o      = (state_q == REFILL) & rf_done_i;
   assign ws_fill_line_o = rf_line_i;
   assign ws_inval_all_o = state_q == FLUSH;

   assign rf_single_o = state_q == IDLE;   // Bypass reads start from IDLE
   assign rf_start_o  = (accept & ~enable_i) | (lookup & ~ws_hit_i);
   assign rf_addr_o   = (state_q == IDLE) ? fetch_req_i.addr : req_q.addr;

   assign evt_o.hit    = lookup & ws_hit_i;
   assign evt_o.miss   = lookup & ~ws_hit_i;
   assign flush_done_o = state_q == FLUSH;

   assign fetch_rsp_valid_o = state_q == RESPOND;
   assign fetch_rsp_o.data  = rsp_word_q;
   assign fetch_rsp_o.id    = req_q.id;

endmodule

//--- source/icache_macros.svh
/*
 * Instruction cache geometry and configuration register map
 */
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// ----------------------------------------------------------
// Geometry
// ----------------------------------------------------------
`define ICACHE_ADDR_W      32
`define ICACHE_WORD_W      32
`define ICACHE_LINE_WORDS  4
`define ICACHE_SETS        16
`define ICACHE_WAYS        2
`define ICACHE_ID_W        4

// Address split, word field sits above the two byte bits
`define ICACHE_OFFSET_W    2
`define ICACHE_INDEX_W     4
`define ICACHE_TAG_W       (`ICACHE_ADDR_W - `ICACHE_INDEX_W - `ICACHE_OFFSET_W - 2)

// ----------------------------------------------------------
// Configuration space
// ----------------------------------------------------------
`define ICACHE_CFG_ADDR_W  4
`define ICACHE_REG_CTRL    4'h0   // Enable bit
`define ICACHE_REG_FLUSH   4'h4   // Invalidate all lines
`define ICACHE_REG_HITS    4'h8
`define ICACHE_REG_MISSES  4'hC

`endif

//--- source/icache_pkg.sv
/*
 * Instruction cache types shared by the controller, store,
 * refill engine and register block
 */
`include "icache_macros.svh"

package icache_pkg;

   // ----------------------------------------------------------
   // Fetch port
   // ----------------------------------------------------------
   typedef struct packed {
      logic [`ICACHE_ADDR_W-1:0] addr;
      logic [`ICACHE_ID_W-1:0]   id;
   } fetch_req_t;

   typedef struct packed {
      logic [`ICACHE_WORD_W-1:0] data;
      logic [`ICACHE_ID_W-1:0]   id;
   } fetch_rsp_t;

   // ----------------------------------------------------------
   // Wishbone classic, memory and configuration ports
   // ----------------------------------------------------------
   typedef struct packed {
      logic                          cyc;
      logic                          stb;
      logic                          we;
      logic [`ICACHE_ADDR_W-1:0]     adr;
      logic [`ICACHE_WORD_W-1:0]     dat;
      logic [`ICACHE_WORD_W/8-1:0]   sel;
   } wb_m2s_t;

   typedef struct packed {
      logic                          ack;
      logic [`ICACHE_WORD_W-1:0]     dat;
   } wb_s2m_t;

   // Word 0 in the low bits
   typedef logic [`ICACHE_LINE_WORDS-1:0][`ICACHE_WORD_W-1:0] cache_line_t;

   typedef struct packed {
      logic hit;
      logic miss;
   } cache_evt_t;

   typedef enum logic [2:0] {
      IDLE, LOOKUP, REFILL, BYPASS, FLUSH, RESPOND
   } cache_state_e;

   typedef enum logic [1:0] {
      REG_CTRL, REG_FLUSH, REG_HITS, REG_MISSES
   } cfg_reg_e;

endpackage

//--- source/icache_refill.sv
/*
 * Wishbone classic read master, fetches a full line or a single word
 */
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_refill
   import icache_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      start_i,
   input  logic                      single_i,
   input  logic [`ICACHE_ADDR_W-1:0] addr_i,
   output logic                      done_o,
   output cache_line_t               line_o,
   output logic [`ICACHE_WORD_W-1:0] word_o,
   output wb_m2s_t                   mem_wb_o,
   input  wb_s2m_t                   mem_wb_i
);

   localparam int BEAT_W   = $clog2(`ICACHE_LINE_WORDS);
   localparam int LINE_LSB = BEAT_W + 2;
   localparam logic [`ICACHE_ADDR_W-1:0] BEAT_BYTES = `ICACHE_WORD_W / 8;

   logic                      cyc_q;
   logic                      single_q;
   logic                      done_q;
   logic [BEAT_W-1:0]         beat_q;
   logic [`ICACHE_ADDR_W-1:0] adr_q;
   cache_line_t               line_q;
   logic                      beat_ok;
   logic                      last_beat;

   assign beat_ok   = cyc_q & mem_wb_i.ack;
   assign last_beat = single_q | (beat_q == '1);

   always_ff @(posedge clk, negedge rst_n)
   begin
      if (!rst_n)
      begin
         cyc_q    <= 1'b0;
         single_q <= 1'b0;
         done_q   <= 1'b0;
         beat_q   <= '0;
      end
      else
      begin
         done_q <= 1'b0;
         if (start_i)
         begin
            cyc_q    <= 1'b1;
            single_q <= single_i;
            beat_q   <= '0;
         end
         else if (beat_ok)
         begin
            beat_q <= beat_q + 1'b1;
            if (last_beat)
            begin
               cyc_q  <= 1'b0;   // Close the cycle after the last beat
               done_q <= 1'b1;
            end
         end
      end
   end

   // Address walk and beat collection
   always_ff @(posedge clk)
   begin
      if (start_i)
         adr_q <= single_i ? {addr_i[`ICACHE_ADDR_W-1:2], 2'b00}
                           : {addr_i[`ICACHE_ADDR_W-1:LINE_LSB], {LINE_LSB{1'b0}}};
      else if (beat_ok)
      begin
         adr_q          <= adr_q + BEAT_BYTES;
         line_q[beat_q] <= mem_wb_i.dat;
      end
   end

   always_comb
   begin
      mem_wb_o     = '0;   // Read only
      mem_wb_o.cyc = cyc_q;
      mem_wb_o.stb = cyc_q;
      mem_wb_o.adr = adr_q;
      mem_wb_o.sel = '1;
   end

   assign done_o = done_q;
   assign line_o = line_q;
   assign word_o = line_q[0];   // Single reads land in slot 0

endmodule

//--- source/icache_top.sv
/*
 * Two-way instruction cache with Wishbone refill and configuration ports
 */
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_top
   import icache_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       fetch_req_valid_i,
   input  fetch_req_t fetch_req_i,
   output logic       fetch_grant_o,
   output logic       fetch_rsp_valid_o,
   output fetch_rsp_t fetch_rsp_o,
   output wb_m2s_t    mem_wb_o,
   input  wb_s2m_t    mem_wb_i,
   input  wb_m2s_t    cfg_wb_i,
   output wb_s2m_t    cfg_wb_o
);

   // Register block to controller
   logic       enable;
   logic       flush_pending;
   logic       flush_done;
   cache_evt_t evt;

   // Controller to store
   logic [`ICACHE_INDEX_W-1:0]  ws_index;
   logic                        ws_lookup;
   logic [`ICACHE_TAG_W-1:0]    ws_tag;
   logic [`ICACHE_OFFSET_W-1:0] ws_word;
   logic                        ws_fill;
   cache_line_t                 ws_fill_line;
   logic                        ws_inval_all;
   logic                        ws_hit;
   logic [`ICACHE_WORD_W-1:0]   ws_hit_word;

   // Controller to refill engine
   logic                        rf_start;
   logic                        rf_single;
   logic [`ICACHE_ADDR_W-1:0]   rf_addr;
   logic                        rf_done;
   cache_line_t                 rf_line;
   logic [`ICACHE_WORD_W-1:0]   rf_word;

   icache_ctrl u_ctrl (
      .clk               (clk),
      .rst_n             (rst_n),
      .fetch_req_valid_i (fetch_req_valid_i),
      .fetch_req_i       (fetch_req_i),
      .fetch_grant_o     (fetch_grant_o),
      .fetch_rsp_valid_o (fetch_rsp_valid_o),
      .fetch_rsp_o       (fetch_rsp_o),
      .enable_i          (enable),
      .flush_pending_i   (flush_pending),
      .flush_done_o      (flush_done),
      .evt_o             (evt),
      .ws_index_o        (ws_index),
      .ws_lookup_o       (ws_lookup),
      .ws_tag_o          (ws_tag),
      .ws_word_o         (ws_word),
      .ws_fill_o         (ws_fill),
      .ws_fill_line_o    (ws_fill_line),
      .ws_inval_all_o    (ws_inval_all),
      .ws_hit_i          (ws_hit),
      .ws_hit_word_i     (ws_hit_word),
      .rf_start_o        (rf_start),
      .rf_single_o       (rf_single),
      .rf_addr_o         (rf_addr),
      .rf_done_i         (rf_done),
      .rf_line_i         (rf_line),
      .rf_word_i         (rf_word)
   );

   icache_way_store u_store (
      .clk         (clk),
      .rst_n       (rst_n),
      .index_i     (ws_index),
      .lookup_i    (ws_lookup),
      .tag_i       (ws_tag),
      .word_sel_i  (ws_word),
      .fill_i      (ws_fill),
      .fill_line_i (ws_fill_line),
      .inval_all_i (ws_inval_all),
      .hit_o       (ws_hit),
      .hit_word_o  (ws_hit_word)
   );

   icache_refill u_refill (
      .clk      (clk),
      .rst_n    (rst_n),
      .start_i  (rf_start),
      .single_i (rf_single),
      .addr_i   (rf_addr),
      .done_o   (rf_done),
      .line_o   (rf_line),
      .word_o   (rf_word),
      .mem_wb_o (mem_wb_o),
      .mem_wb_i (mem_wb_i)
   );

   icache_cfg_regs u_cfg (
      .clk             (clk),
      .rst_n           (rst_n),
      .cfg_wb_i        (cfg_wb_i),
      .cfg_wb_o        (cfg_wb_o),
      .evt_i           (evt),
      .flush_done_i    (flush_done),
      .enable_o        (enable),
      .flush_pending_o (flush_pending)
   );

endmodule

//--- source/icache_way_store.sv
/*
 * Two-way tag, valid and data store with FIFO replacement per set
 */
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_way_store
   import icache_pkg::*;
(
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic [`ICACHE_INDEX_W-1:0]  index_i,
   input  logic                        lookup_i,
   input  logic [`ICACHE_TAG_W-1:0]    tag_i,
   input  logic [`ICACHE_OFFSET_W-1:0] word_sel_i,
   input  logic                        fill_i,
   input  cache_line_t                 fill_line_i,
   input  logic                        inval_all_i,
   output logic                        hit_o,
   output logic [`ICACHE_WORD_W-1:0]   hit_word_o
);

   localparam int WAY_W = $clog2(`ICACHE_WAYS);

   // Arrays
   logic [`ICACHE_TAG_W-1:0]                  tag_mem  [`ICACHE_WAYS][`ICACHE_SETS];
   cache_line_t                               data_mem [`ICACHE_WAYS][`ICACHE_SETS];
   logic [`ICACHE_SETS-1:0][`ICACHE_WAYS-1:0] valid_q;
   logic [`ICACHE_SETS-1:0][WAY_W-1:0]        victim_q;

   // Lookup stage
   logic [`ICACHE_TAG_W-1:0] rd_tag  [`ICACHE_WAYS];
   cache_line_t              rd_line [`ICACHE_WAYS];
   logic [`ICACHE_WAYS-1:0]  rd_valid;
   logic [`ICACHE_WAYS-1:0]  way_hit;
   logic [WAY_W-1:0]         hit_way;
   logic [WAY_W-1:0]         fill_way;

   // Invalid way first, else the set's victim
   always_comb
   begin
      fill_way = victim_q[index_i];
      for (int w = `ICACHE_WAYS-1; w >= 0; w--)
      begin
         if (!valid_q[index_i][w])
            fill_way = WAY_W'(w);
      end
   end

   // ----------------------------------------------------------
   // Valid and replacement state
   // ----------------------------------------------------------
   always_ff @(posedge clk, negedge rst_n)
   begin
      if (!rst_n)
      begin
         valid_q  <= '0;
         victim_q <= '0;
         rd_valid <= '0;
      end
      else
      begin
         if (inval_all_i)
            valid_q <= '0;
         else if (fill_i)
         begin
            valid_q[index_i][fill_way] <= 1'b1;
            victim_q[index_i]          <= fill_way + 1'b1;   // Oldest fill goes next
         end
         if (lookup_i)
            rd_valid <= valid_q[index_i];
      end
   end

   always_ff @(posedge clk)
   begin
      if (fill_i)
      begin
         tag_mem[fill_way][index_i]  <= tag_i;
         data_mem[fill_way][index_i] <= fill_line_i;
      end
      if (lookup_i)
      begin
         for (int w = 0; w < `ICACHE_WAYS; w++)
         begin
            rd_tag[w]  <= tag_mem[w][index_i];
            rd_line[w] <= data_mem[w][index_i];
         end
      end
   end

   // ----------------------------------------------------------
   // Tag compare and word select
   // ----------------------------------------------------------
   always_comb
   begin
      hit_way = '0;
      for (int w = 0; w < `ICACHE_WAYS; w++)
      begin
         way_hit[w] = rd_valid[w] && (rd_tag[w] == tag_i);
         if (way_hit[w])
            hit_way = WAY_W'(w);
      end
   end

   assign hit_o      = |way_hit;
   assign hit_word_o = rd_line[hit_way][word_sel_i];

endmodule
